//--- Makefile
# Verilator build for the flash word reader testbench.
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= flash_fetch_tb
FILELIST  ?= flash_fetch.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/flash_fetch_defs.svh

.PHONY: compile run clean

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- flash_fetch.f
+incdir+hw
hw/flash_fetch_pkg.sv
hw/flash_fetch_if.sv
hw/fetch_front.sv
hw/flash_read_engine.sv
hw/spi_bit_clock.sv
hw/flash_fetch_top.sv
sim/spi_flash_model.sv
sim/flash_fetch_props.sv
sim/flash_fetch_tb.sv

//--- hw/fetch_front.sv
/*
 * Request front end of the flash word reader.
 * Holds the last fetched word with its word address, answers a repeated
 * address straight from that buffer and runs the request/ready level protocol.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_front
    import flash_fetch_pkg::*;
(
    input  logic          i_clock,
    input  logic          i_rst_n,
    input  logic          i_request,
    input  logic [31:0]   i_address,
    output flash_word_t   o_rdata,
    output logic          o_ready,
    flash_rd_if.requester rd
);

    front_state_t state;
    flash_word_t  buf_word;             // Last word fetched from flash.
    logic [21:0]  buf_tag;              // Address bits 23..2 of buf_word.
    logic         buf_valid;
    flash_addr_t  addr_q;
    logic         req_q;
    logic         ready_q;
    logic         hit;

    // Low two bits and bits 31..24 take no part in the compare.
    assign hit = buf_valid && (buf_tag == i_address[23:2]);

    assign rd.req   = req_q;
    assign rd.addr  = addr_q;
    assign o_rdata  = buf_word;
    assign o_ready  = ready_q;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state     <= F_IDLE;
            req_q     <= 1'b0;
            ready_q   <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    ready_q <= 1'b0;
                    if (i_request) begin
                        if (hit) begin
                            state <= F_HOLD;    // Ready follows one clock later.
                        end else begin
                            req_q <= 1'b1;
                            state <= F_FETCH;
                        end
                    end
                end
                F_FETCH: begin
                    if (rd.done) begin
                        req_q     <= 1'b0;      // Engine sees req low next cycle.
                        buf_valid <= 1'b1;
                        ready_q   <= i_request;
                        state     <= F_HOLD;
                    end
                end
                F_HOLD: begin
                    ready_q <= i_request;       // Drops the clock after i_request.
                    if (!i_request) begin
                        state <= F_IDLE;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == F_IDLE && i_request && !hit) begin
            addr_q <= {i_address[23:2], 2'b00};
        end
        if (state == F_FETCH && rd.done) begin
            buf_word <= rd.rdata;
            buf_tag  <= addr_q[23:2];
        end
    end

endmodule

`default_nettype wire

//--- hw/flash_fetch_defs.svh
/*
 * Constants for the serial flash word reader:
 *   SCK half period in system clocks,
 *   bit counts of the command/address and data phases,
 *   width of the flash address.
 */

`ifndef FLASH_FETCH_DEFS_SVH
`define FLASH_FETCH_DEFS_SVH

// System clocks per SCK half period. Any value of 1 or more is fine.
`define FLASH_SCK_HALF 2

// Opcode plus address, shifted out MSB first.
`define FLASH_CMD_BITS 32

`define FLASH_DATA_BITS 32

`define FLASH_ADDR_BITS 24

`endif

//--- hw/flash_fetch_if.sv
/*
 * Internal interfaces of the flash word reader:
 *   flash_rd_if   word request from the front end to the read engine,
 *   spi_phase_if  SCK and shift/sample strobes between engine and bit clock.
 */

`timescale 1ns/1ps
`default_nettype none

interface flash_rd_if import flash_fetch_pkg::*; ();

    logic        req;                   // Level, held until done.
    flash_addr_t addr;                  // Word aligned, stable while req is high.
    logic        done;                  // One cycle pulse, rdata valid with it.
    flash_word_t rdata;

    modport requester (output req, output addr, input done, input rdata);
    modport responder (input req, input addr, output done, output rdata);

endinterface

interface spi_phase_if ();

    logic enable;                       // Keeps SCK running while high.
    logic sck;
    logic shift_stb;                    // Cycle that ends with SCK falling.
    logic sample_stb;                   // Cycle that ends with SCK rising.

    modport master (
        output enable,
        input  sck, shift_stb, sample_stb
    );
    modport clock_gen (
        input  enable,
        output sck, shift_stb, sample_stb
    );

endinterface

`default_nettype wire

//--- hw/flash_fetch_pkg.sv
/*
 * Shared types for the serial flash word reader:
 *   data word and flash address types,
 *   flash opcode enum,
 *   read engine and request front end state enums.
 */

`default_nettype none

package flash_fetch_pkg;

    typedef logic [31:0] flash_word_t;  // Word returned to the requester.
    typedef logic [23:0] flash_addr_t;  // Byte address inside the 16 MB flash.

    typedef enum logic [7:0] {
        CMD_READ = 8'h03                // Standard slow read.
    } flash_cmd_t;

    typedef enum logic [1:0] {
        E_IDLE,
        E_SEND_CMD,
        E_RECV_DAT,
        E_DONE
    } engine_state_t;

    typedef enum logic [1:0] {
        F_IDLE,
        F_FETCH,
        F_HOLD
    } front_state_t;

endpackage

`default_nettype wire

//--- hw/flash_fetch_top.sv
/*
 * Top level of the flash word reader.
 * Connects the request front end, the read engine and the SPI bit clock,
 * with the requester and the flash pins as plain ports.
 */

`timescale 1ns/1ps
`default_nettype none

module flash_fetch_top
    import flash_fetch_pkg::*;
(
    input  logic        i_clock,
    input  logic        i_rst_n,
    input  logic        i_request,
    input  logic [31:0] i_address,
    output flash_word_t o_rdata,
    output logic        o_ready,
    output logic        o_spi_cs_n,
    output logic        o_spi_sck,
    output logic        o_spi_mosi,
    input  logic        i_spi_miso
);

    flash_rd_if  rd_bus ();
    spi_phase_if ph_bus ();

    assign o_spi_sck = ph_bus.sck;

    fetch_front u_front (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_request (i_request),
        .i_address (i_address),
        .o_rdata   (o_rdata),
        .o_ready   (o_ready),
        .rd        (rd_bus.requester)
    );

    flash_read_engine u_engine (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .rd         (rd_bus.responder),
        .ph         (ph_bus.master),
        .o_spi_cs_n (o_spi_cs_n),
        .o_spi_mosi (o_spi_mosi),
        .i_spi_miso (i_spi_miso)
    );

    spi_bit_clock u_bit_clock (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .ph      (ph_bus.clock_gen)
    );

endmodule

`default_nettype wire

//--- hw/flash_read_engine.sv
/*
 * Serial flash read engine.
 * Sends the READ opcode and a 24-bit address MSB first on falling SCK,
 * then gathers four data bytes on rising SCK and returns them as a
 * little-endian word with a one-cycle done pulse.
 */

`timescale 1ns/1ps
`default_nettype none

`include "flash_fetch_defs.svh"

module flash_read_engine
    import flash_fetch_pkg::*;
(
    input  logic          i_clock,
    input  logic          i_rst_n,
    flash_rd_if.responder rd,
    spi_phase_if.master   ph,
    output logic          o_spi_cs_n,
    output logic          o_spi_mosi,
    input  logic          i_spi_miso
);

    localparam int MAX_BITS = (`FLASH_CMD_BITS > `FLASH_DATA_BITS) ?
                              `FLASH_CMD_BITS : `FLASH_DATA_BITS;
    localparam int CNT_W    = $clog2(MAX_BITS + 1);

    engine_state_t               state;
    logic [`FLASH_CMD_BITS-1:0]  cmd_sr;    // Opcode and address, MSB on MOSI.
    logic [`FLASH_DATA_BITS-1:0] rx_sr;
    logic [CNT_W-1:0]            bit_cnt;   // Bits left in the current phase.
    logic                        enable_q;
    logic                        done_q;

    assign o_spi_mosi = cmd_sr[`FLASH_CMD_BITS-1];
    assign ph.enable  = enable_q;
    assign rd.done    = done_q;

    // First byte on the wire lands in bits 7..0.
    assign rd.rdata = {rx_sr[7:0], rx_sr[15:8], rx_sr[23:16], rx_sr[31:24]};

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state      <= E_IDLE;
            o_spi_cs_n <= 1'b1;
            enable_q   <= 1'b0;
            done_q     <= 1'b0;
            cmd_sr     <= '0;
            bit_cnt    <= '0;
        end else begin
            done_q <= 1'b0;
            case (state)
                E_IDLE: begin
                    // req is still high in the done cycle, so skip that one.
                    if (rd.req && !done_q) begin
                        o_spi_cs_n <= 1'b0;
                        enable_q   <= 1'b1;
                        cmd_sr     <= {CMD_READ, rd.addr[`FLASH_ADDR_BITS-1:0]};
                        bit_cnt    <= CNT_W'(`FLASH_CMD_BITS);
                        state      <= E_SEND_CMD;
                    end
                end
                E_SEND_CMD: begin
                    if (ph.shift_stb) begin
                        cmd_sr <= {cmd_sr[`FLASH_CMD_BITS-2:0], 1'b0};
                        if (bit_cnt == CNT_W'(1)) begin
                            bit_cnt <= CNT_W'(`FLASH_DATA_BITS);
                            state   <= E_RECV_DAT;
                        end else begin
                            bit_cnt <= bit_cnt - CNT_W'(1);
                        end
                    end
                end
                E_RECV_DAT: begin
                    if (ph.sample_stb) begin
                        if (bit_cnt == CNT_W'(1)) begin
                            state <= E_DONE;
                        end else begin
                            bit_cnt <= bit_cnt - CNT_W'(1);
                        end
                    end
                end
                E_DONE: begin
                    // Close the transfer on the falling edge so SCK ends low.
                    if (ph.shift_stb) begin
                        o_spi_cs_n <= 1'b1;
                        enable_q   <= 1'b0;
                        done_q     <= 1'b1;
                        state      <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == E_RECV_DAT && ph.sample_stb) begin
            rx_sr <= {rx_sr[`FLASH_DATA_BITS-2:0], i_spi_miso};
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_bit_clock.sv
/*
 * SPI bit clock for mode 0 transfers.
 * Divides the system clock into SCK and flags the cycles that end with a
 * rising edge (sample) or a falling edge (shift) while enabled.
 */

`timescale 1ns/1ps
`default_nettype none

`include "flash_fetch_defs.svh"

module spi_bit_clock (
    input  logic            i_clock,
    input  logic            i_rst_n,
    spi_phase_if.clock_gen  ph
);

    localparam int               DIV_W    = $clog2(`FLASH_SCK_HALF + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`FLASH_SCK_HALF - 1);

    logic [DIV_W-1:0] div_cnt;          // Clocks spent in the current half period.
    logic             sck_q;
    logic             edge_due;         // SCK toggles at the end of this cycle.

    assign edge_due      = ph.enable && (div_cnt == DIV_LAST);
    assign ph.sck        = sck_q;
    assign ph.sample_stb = edge_due && !sck_q;
    assign ph.shift_stb  = edge_due && sck_q;

    always_ff @(posedge i_clock) begin
        if (!i_rst_n || !ph.enable) begin
            div_cnt <= '0;
            sck_q   <= 1'b0;                // Idle low between transfers.
        end else if (div_cnt == DIV_LAST) begin
            div_cnt <= '0;
            sck_q   <= ~sck_q;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

endmodule

`default_nettype wire

//--- sim/flash_fetch_props.sv
/*
 * Concurrent assertions on the flash word reader, bound to the top level:
 * SPI pin rules in mode 0 and the request/ready protocol.
 */

`timescale 1ns/1ps
`default_nettype none

module flash_fetch_props (
    input logic i_clock,
    input logic i_rst_n,
    input logic i_request,
    input logic i_ready,
    input logic i_spi_cs_n,
    input logic i_spi_sck,
    input logic i_spi_mosi
);

    sck_low_when_idle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_spi_cs_n |-> !i_spi_sck)
        else $error("SCK is high while chip select is inactive");

    ready_needs_request: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        $rose(i_ready) |-> $past(i_request))
        else $error("ready rose without a pending request");

    // Data may only change on the falling SCK edge.
    mosi_stable_sck_high: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_spi_sck |-> $stable(i_spi_mosi))
        else $error("MOSI changed while SCK was high");

    ready_flash_idle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_ready |-> i_spi_cs_n)
        else $error("ready is high during a flash transfer");

endmodule

bind flash_fetch_top flash_fetch_props u_props (
    .i_clock    (i_clock),
    .i_rst_n    (i_rst_n),
    .i_request  (i_request),
    .i_ready    (o_ready),
    .i_spi_cs_n (o_spi_cs_n),
    .i_spi_sck  (o_spi_sck),
    .i_spi_mosi (o_spi_mosi)
);

`default_nettype wire

//--- sim/flash_fetch_tb.sv
/*
 * Testbench for the flash word reader.
 * Runs a table of requests against the DUT and a behavioral flash,
 * checking the returned word, chip select activity, hit latency and the
 * ready protocol. Holds the clock, reset, watchdog and compare tasks.
 */

`timescale 1ns/1ps
`default_nettype none

`include "flash_fetch_defs.svh"

module flash_fetch_tb
    import flash_fetch_pkg::*;
();

    typedef struct {
        string       name;
        logic [31:0] addr;
        int          hold;          // Extra cycles i_request stays high after ready.
        logic        hit;           // Chip select expected to stay high.
        logic        rst_before;
    } test_row_t;

    test_row_t   rows[$];
    bit          table_ready;
    logic        clock;
    logic        rst_n;
    logic        request;
    logic [31:0] address;
    flash_word_t rdata;
    logic        ready;
    logic        spi_cs_n;
    logic        spi_sck;
    logic        spi_mosi;
    logic        spi_miso;
    logic        bad_cmd;

    flash_fetch_top dut (
        .i_clock    (clock),
        .i_rst_n    (rst_n),
        .i_request  (request),
        .i_address  (address),
        .o_rdata    (rdata),
        .o_ready    (ready),
        .o_spi_cs_n (spi_cs_n),
        .o_spi_sck  (spi_sck),
        .o_spi_mosi (spi_mosi),
        .i_spi_miso (spi_miso)
    );

    spi_flash_model u_flash (
        .i_spi_cs_n (spi_cs_n),
        .i_spi_sck  (spi_sck),
        .i_spi_mosi (spi_mosi),
        .o_spi_miso (spi_miso),
        .o_bad_cmd  (bad_cmd)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Flash bytes of A..A+3 from low byte to high byte, A word aligned.
    function automatic flash_word_t model_word(input logic [31:0] addr);
        flash_addr_t base;
        flash_word_t word;
        base = {addr[23:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = 8'(base + flash_addr_t'(i)) ^ 8'h5A;
        end
        return word;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input flash_word_t exp, input flash_word_t act);
        if (act !== exp) stop_run($sformatf("ERROR %s: expected %h, got %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) stop_run($sformatf("ERROR %s: expected %b, got %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) stop_run($sformatf("ERROR %s: expected %0d, got %0d", name, exp, act));
    endtask

    task automatic add_row(input string name, input logic [31:0] addr, input int hold,
                           input logic hit, input logic rst_before);
        test_row_t row;
        row = '{name, addr, hold, hit, rst_before};
        rows.push_back(row);
    endtask

    task automatic apply_reset();
        rst_n   = 1'b0;
        request = 1'b0;
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;
        check_flag("reset ready", 1'b0, ready);
        check_flag("reset cs_n", 1'b1, spi_cs_n);
        check_flag("reset sck", 1'b0, spi_sck);
        check_flag("reset mosi", 1'b0, spi_mosi);
    endtask

    // Starts a flash read and returns while SCK and MOSI are both high.
    task automatic start_partial_fetch(input logic [31:0] addr);
        request = 1'b1;
        address = addr;
        while (!(spi_sck === 1'b1 && spi_mosi === 1'b1)) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic run_row(input test_row_t row);
        int          cycles;
        logic        cs_seen;
        flash_word_t exp;
        cycles  = 0;
        cs_seen = 1'b0;
        exp     = model_word(row.addr);
        request = 1'b1;
        address = row.addr;
        while (ready !== 1'b1) begin
            @(posedge clock);
            #1;
            cycles++;
            if (spi_cs_n === 1'b0) cs_seen = 1'b1;
        end
        if (row.hit) check_count({row.name, " hit latency"}, 2, cycles);
        check_word(row.name, exp, rdata);
        repeat (row.hold) begin
            @(posedge clock);
            #1;
            if (spi_cs_n === 1'b0) cs_seen = 1'b1;
            check_flag({row.name, " ready held"}, 1'b1, ready);
            check_word({row.name, " word held"}, exp, rdata);
        end
        check_flag({row.name, " cs_n activity"}, !row.hit, cs_seen);
        request = 1'b0;
        @(posedge clock);
        #1;
        check_flag({row.name, " ready after drop"}, 1'b0, ready);
    endtask

    initial begin
        int gap;
        rst_n   = 1'b0;
        request = 1'b0;
        address = '0;
        void'($urandom(92939));
        add_row("miss_aligned",     32'h0000_1230, 3,  1'b0, 1'b0);
        add_row("hit_repeat",       32'h0000_1230, 2,  1'b1, 1'b0);
        add_row("miss_unaligned",   32'h0000_4567, 2,  1'b0, 1'b0);
        add_row("hit_upper_bits",   32'hAB00_4565, 2,  1'b1, 1'b0);
        add_row("miss_upper_bits",  32'hFF12_3459, 1,  1'b0, 1'b0);
        add_row("long_hold",        32'h0012_345A, 20, 1'b1, 1'b0);
        add_row("miss_after_reset", 32'h0012_3458, 3,  1'b0, 1'b1);
        add_row("hit_after_refill", 32'h0012_3458, 1,  1'b1, 1'b0);
        add_row("top_of_flash",     32'h00FF_FFFF, 2,  1'b0, 1'b0);
        table_ready = 1'b1;
        apply_reset();
        foreach (rows[i]) begin
            if (rows[i].rst_before) begin
                start_partial_fetch(32'h0000_0F00);  // Reset lands inside a flash transfer.
                apply_reset();
            end
            run_row(rows[i]);
            gap = 1 + int'($urandom % 4);   // Idle clocks before the next request.
            repeat (gap) @(posedge clock);
            #1;
        end
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() * (2 * `FLASH_SCK_HALF * 70 + 64)) @(posedge clock);
        stop_run("watchdog expired before all requests were answered");
    end

    initial begin
        wait (bad_cmd === 1'b1);
        stop_run("flash model received an opcode other than READ");
    end

endmodule

`default_nettype wire

//--- sim/spi_flash_model.sv
/*
 * Behavioral serial NOR flash for simulation.
 * Takes the opcode and a 24-bit address in SPI mode 0, then returns bytes
 * whose value is the low address byte XOR 0x5A, MSB first.
 * Raises o_bad_cmd if the opcode is not READ.
 */

`timescale 1ns/1ps
`default_nettype none

`include "flash_fetch_defs.svh"

module spi_flash_model
    import flash_fetch_pkg::*;
(
    input  logic i_spi_cs_n,
    input  logic i_spi_sck,
    input  logic i_spi_mosi,
    output logic o_spi_miso,
    output logic o_bad_cmd
);

    logic [`FLASH_CMD_BITS-1:0] cmd_sr;   // Opcode and address as received.
    flash_addr_t                addr;
    logic [7:0]                 data_byte;
    int                         bit_cnt;  // Rising SCK edges since CS fell.
    int                         data_idx;
    logic                       in_xfer;

    initial begin
        o_spi_miso = 1'b0;
        o_bad_cmd  = 1'b0;
        cmd_sr     = '0;
        forever begin
            @(negedge i_spi_cs_n);
            bit_cnt = 0;
            in_xfer = 1'b1;
            while (in_xfer) begin
                @(posedge i_spi_sck or negedge i_spi_sck or posedge i_spi_cs_n);
                if (i_spi_cs_n === 1'b1) begin
                    in_xfer    = 1'b0;
                    o_spi_miso = 1'b0;
                end else if (i_spi_sck === 1'b1) begin
                    if (bit_cnt < `FLASH_CMD_BITS) begin
                        cmd_sr = {cmd_sr[`FLASH_CMD_BITS-2:0], i_spi_mosi};
                    end
                    bit_cnt++;
                end else if (bit_cnt >= `FLASH_CMD_BITS) begin
                    if (bit_cnt == `FLASH_CMD_BITS && cmd_sr[31:24] != CMD_READ) begin
                        o_bad_cmd = 1'b1;
                    end
                    addr     = cmd_sr[`FLASH_ADDR_BITS-1:0];
                    data_idx = bit_cnt - `FLASH_CMD_BITS;
                    if (data_idx < `FLASH_DATA_BITS) begin
                        data_byte  = 8'(addr + flash_addr_t'(data_idx / 8)) ^ 8'h5A;
                        o_spi_miso = data_byte[7 - (data_idx % 8)];  // MSB first.
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire
